//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/fetch_tb.sv
`default_nettype none

module fetch_tb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef logic [fetch_pkg::DATA_W-1:0] word_t;

   localparam int    CLK_NS      = 4;
   localparam int    DRIVE_NS    = 1;      // Input skew after the rising edge
   localparam int    TEST_CYCLES = 2000;   // Rough sum over all tests
   localparam int    LOAD_WORDS  = 64;
   localparam word_t BAD_ADDR    = 32'h0000_0400;   // First unmapped byte
   // Control patterns, order pc_we if_id_we beq jmp flush
   localparam fetch_pkg::fetch_ctrl_t C_IDLE  = 5'b00000;
   localparam fetch_pkg::fetch_ctrl_t C_SEQ   = 5'b11000;
   localparam fetch_pkg::fetch_ctrl_t C_PCSTL = 5'b01000;   // Counter stalled
   localparam fetch_pkg::fetch_ctrl_t C_IFSTL = 5'b10000;   // IF/ID stalled
   localparam fetch_pkg::fetch_ctrl_t C_BEQ   = 5'b11100;
   localparam fetch_pkg::fetch_ctrl_t C_JMP   = 5'b11010;
   localparam fetch_pkg::fetch_ctrl_t C_BOTH  = 5'b11110;
   localparam fetch_pkg::fetch_ctrl_t C_FLUSH = 5'b11001;

   logic                   clk = 1'b0;
   logic                   rst;
   fetch_pkg::axil_req_t   req;
   fetch_pkg::axil_rsp_t   rsp;
   fetch_pkg::fetch_ctrl_t ctrl;
   fetch_pkg::redirect_t   redir;
   fetch_pkg::if_id_t      if_id;

   word_t  mem_model [fetch_pkg::RAM_DEPTH];   // Expected program words
   word_t  m_pc;
   word_t  m_if_pc;
   word_t  m_word;                              // Model memory output register
   logic   m_flushed;
   logic   m_run;
   integer seed = 32'ha166_428b;
   int     errors = 0;
   int     passed = 0;
   int     failed = 0;

   fetch_top dut (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_axil     (req),
      .o_axil     (rsp),
      .i_ctrl     (ctrl),
      .i_redirect (redir),
      .o_if_id    (if_id)
   );

   bind fetch_top fetch_tb_assertions u_checks (
      .i_clk (i_clk), .i_rst (i_rst), .i_req (i_axil), .i_rsp (o_axil),
      .i_run (run), .i_ctrl (i_ctrl), .i_if_id (o_if_id)
   );

   always #(CLK_NS / 2) clk = ~clk;

   task automatic tick();
      @(posedge clk);
      #DRIVE_NS;   // Outputs settled, safe to drive
   endtask

   task automatic compare_if_id(input fetch_pkg::if_id_t exp, input fetch_pkg::if_id_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: o_if_id expected pc %h instr %h, got pc %h instr %h",
                  $time, exp.pc, exp.instr, act.pc, act.instr);
      end
   endtask

   task automatic compare_data(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic compare_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      end
   endtask

   task automatic axil_write(input word_t addr, input word_t data, input logic [3:0] strb,
                             input logic [1:0] exp_resp);
      req.awvalid = 1'b1;
      req.awaddr  = addr;
      req.wvalid  = 1'b1;
      req.wdata   = data;
      req.wstrb   = strb;
      do tick(); while (!(rsp.awready && rsp.wready));   // Both readies pulse together
      tick();                             // Handshake edge
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      while (!rsp.bvalid) tick();
      repeat (2) tick();                  // Response left pending a while
      compare_resp("bresp", exp_resp, rsp.bresp);
      req.bready = 1'b1;
      tick();
      req.bready = 1'b0;
   endtask

   task automatic axil_read(input word_t addr, input word_t exp_data, input logic [1:0] exp_resp);
      req.arvalid = 1'b1;
      req.araddr  = addr;
      do tick(); while (!rsp.arready);
      tick();
      req.arvalid = 1'b0;
      while (!rsp.rvalid) tick();
      repeat (2) tick();                  // Data must hold while rready is low
      compare_data("rdata", exp_data, rsp.rdata);
      compare_resp("rresp", exp_resp, rsp.rresp);
      req.rready = 1'b1;
      tick();
      req.rready = 1'b0;
   endtask

   // Fetch idle while the run bit changes
   task automatic set_run(input logic value);
      ctrl = C_IDLE;
      axil_write(fetch_pkg::CTRL_ADDR, {31'b0, value}, 4'hf, fetch_pkg::RESP_OKAY);
      m_run = value;
   endtask

   // One clock of the fetch rules, old state on the right
   task automatic model_step(input fetch_pkg::fetch_ctrl_t c, input fetch_pkg::redirect_t r);
      word_t nxt;
      if (c.jmp) nxt = {m_if_pc[31:28], r.jmp_addr};
      else if (c.beq) nxt = r.brq_addr;
      else nxt = m_pc + 4;
      if (m_run && c.if_id_we) begin
         m_if_pc   = m_pc + 4;
         m_word    = mem_model[m_pc[fetch_pkg::RAM_AW+1:2]];
         m_flushed = c.flush;
      end
      if (m_run && c.pc_we) m_pc = nxt;
   endtask

   task automatic fetch_cycle(input fetch_pkg::fetch_ctrl_t c, input fetch_pkg::redirect_t r);
      fetch_pkg::if_id_t exp;
      ctrl  = c;
      redir = r;
      tick();
      model_step(c, r);
      exp.pc    = m_if_pc;
      exp.instr = m_flushed ? fetch_pkg::NOP_INSTR : m_word;
      compare_if_id(exp, if_id);
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         passed++;
         $display("%s: passed", name);
      end else begin
         failed++;
         $display("%s: failed with %0d mismatches", name, errors - errors_before);
      end
   endtask

   task automatic test_reset_state();
      int e0;
      e0 = errors;
      compare_if_id({32'h0, fetch_pkg::NOP_INSTR}, if_id);
      axil_read(fetch_pkg::CTRL_ADDR, '0, fetch_pkg::RESP_OKAY);   // run clear
      axil_read(32'h0, '0, fetch_pkg::RESP_OKAY);
      axil_read(32'h3fc, '0, fetch_pkg::RESP_OKAY);                // Last word
      report_test("reset state", e0);
   endtask

   task automatic test_load_readback();
      int e0;
      e0 = errors;
      for (int i = 0; i < LOAD_WORDS; i++) begin
         mem_model[i] = $random(seed);
         axil_write(i * 4, mem_model[i], 4'hf, fetch_pkg::RESP_OKAY);
      end
      for (int i = 0; i < LOAD_WORDS; i++) axil_read(i * 4, mem_model[i], fetch_pkg::RESP_OKAY);
      axil_write(32'h8, 32'ha5a5_5a5a, 4'b0101, fetch_pkg::RESP_OKAY);   // Lanes 0 and 2
      mem_model[2] = {mem_model[2][31:24], 8'ha5, mem_model[2][15:8], 8'h5a};
      axil_read(32'h8, mem_model[2], fetch_pkg::RESP_OKAY);
      axil_write(BAD_ADDR, 32'hdead_beef, 4'hf, fetch_pkg::RESP_SLVERR);
      axil_read(BAD_ADDR, '0, fetch_pkg::RESP_SLVERR);
      report_test("load and readback", e0);
   endtask

   task automatic test_sequential();
      int e0;
      e0 = errors;
      set_run(1'b1);
      repeat (20) fetch_cycle(C_SEQ, '0);
      report_test("sequential fetch", e0);
   endtask

   task automatic test_stalls();
      int e0;
      e0 = errors;
      repeat (3) fetch_cycle(C_PCSTL, '0);   // Same word fetched again
      repeat (3) fetch_cycle(C_IFSTL, '0);   // Outputs frozen, pc runs on
      repeat (2) fetch_cycle(C_SEQ, '0);
      set_run(1'b0);
      repeat (4) fetch_cycle(C_SEQ, '0);     // Nothing moves without run
      set_run(1'b1);
      repeat (3) fetch_cycle(C_SEQ, '0);
      report_test("stalls and run gating", e0);
   endtask

   task automatic test_redirect();
      int                   e0;
      fetch_pkg::redirect_t r;
      e0 = errors;
      r = '0;
      r.brq_addr = 32'h1000_0010;            // Upper nibble set for the jump
      fetch_cycle(C_BEQ, r);
      repeat (2) fetch_cycle(C_SEQ, r);
      r.jmp_addr = 28'h000_0080;
      fetch_cycle(C_JMP, r);
      repeat (2) fetch_cycle(C_SEQ, r);
      r.brq_addr = 32'h0000_0020;
      r.jmp_addr = 28'h000_0040;
      fetch_cycle(C_BOTH, r);                // Jump wins
      repeat (2) fetch_cycle(C_SEQ, r);
      fetch_cycle(C_FLUSH, r);               // Bubble on the output
      repeat (2) fetch_cycle(C_SEQ, r);
      report_test("branch, jump and flush", e0);
   endtask

   // Watchdog
   initial begin
      repeat (2 * TEST_CYCLES) @(posedge clk);
      $display("Timeout: tests still running after %0d cycles", 2 * TEST_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      rst   = 1'b1;
      req   = '0;
      ctrl  = C_IDLE;
      redir = '0;
      for (int i = 0; i < fetch_pkg::RAM_DEPTH; i++) mem_model[i] = '0;
      m_pc      = '0;
      m_if_pc   = '0;
      m_word    = '0;
      m_flushed = 1'b1;   // Bubble out of reset
      m_run     = 1'b0;
      repeat (3) @(posedge clk);
      #DRIVE_NS rst = 1'b0;
      test_reset_state();
      test_load_readback();
      test_sequential();
      test_stalls();
      test_redirect();
      $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
               passed, failed, dut.u_checks.fail_count);
      if (failed == 0 && dut.u_checks.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/fetch_tb_assertions.sv
`default_nettype none

module fetch_tb_assertions (
   input wire logic                   i_clk,
   input wire logic                   i_rst,
   input wire fetch_pkg::axil_req_t   i_req,     // Master side of the loader bus
   input wire fetch_pkg::axil_rsp_t   i_rsp,
   input wire logic                   i_run,
   input wire fetch_pkg::fetch_ctrl_t i_ctrl,
   input wire fetch_pkg::if_id_t      i_if_id
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;   // Failed assertion tally

   // Write response held until bready
   bvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp.bvalid && !i_req.bready |=> i_rsp.bvalid)
      else begin
         $error("bvalid dropped before bready");
         fail_count++;
      end

   rvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp.rvalid && !i_req.rready |=> i_rsp.rvalid)
      else begin
         $error("rvalid dropped before rready");
         fail_count++;
      end

   // Read data frozen while waiting
   rdata_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rsp.rvalid && !i_req.rready |=> $stable(i_rsp.rdata))
      else begin
         $error("rdata changed while rvalid was pending");
         fail_count++;
      end

   // Effective IF/ID enable low, pc field holds
   if_id_pc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_run && i_ctrl.if_id_we) |=> $stable(i_if_id.pc))
      else begin
         $error("IF/ID pc moved while the register was stalled");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- src/axil_prog_loader.sv
`default_nettype none

module axil_prog_loader (
   input  wire logic                            i_clk,
   input  wire logic                            i_rst,
   input  wire fetch_pkg::axil_req_t            i_axil,
   output fetch_pkg::axil_rsp_t                 o_axil,
   output fetch_pkg::ram_port_t                 o_ram,        // To memory port B
   input  wire logic [fetch_pkg::DATA_W-1:0]    i_ram_rdata,
   output logic                                 o_run
);

   typedef enum logic [1:0] {W_IDLE, W_ACC, W_RESP} wr_state_t;
   typedef enum logic [1:0] {R_IDLE, R_ACC, R_WAIT, R_RESP} rd_state_t;

   wr_state_t                    w_state;
   rd_state_t                    r_state;
   logic                         wr_start;
   logic                         rd_start;
   logic                         wr_mem;      // awaddr hits program space
   logic                         wr_ctrl;     // awaddr hits control word
   logic                         ar_mem;
   logic                         ar_ctrl;
   logic                         rd_mem;      // Read decode kept for the data cycle
   logic                         rd_ctrl;
   logic [1:0]                   bresp;
   logic [1:0]                   rresp;
   logic [fetch_pkg::DATA_W-1:0] rdata;
   logic                         run;

   function automatic logic in_ram(input logic [fetch_pkg::DATA_W-1:0] a);
      logic [fetch_pkg::DATA_W-1:0] off;
      off = a - fetch_pkg::RAM_BASE;
      return off < fetch_pkg::RAM_BYTES;
   endfunction

   function automatic logic [fetch_pkg::RAM_AW-1:0] word_addr(
      input logic [fetch_pkg::DATA_W-1:0] a);
      logic [fetch_pkg::DATA_W-1:0] off;
      off = a - fetch_pkg::RAM_BASE;
      return off[fetch_pkg::RAM_AW+1:2];
   endfunction

   // Byte lane bits ignored
   function automatic logic is_ctrl(input logic [fetch_pkg::DATA_W-1:0] a);
      return a[fetch_pkg::DATA_W-1:2] == fetch_pkg::CTRL_ADDR[fetch_pkg::DATA_W-1:2];
   endfunction

   assign wr_mem  = in_ram(i_axil.awaddr);
   assign wr_ctrl = is_ctrl(i_axil.awaddr);
   assign ar_mem  = in_ram(i_axil.araddr);
   assign ar_ctrl = is_ctrl(i_axil.araddr);

   // Port B is shared, a write start blocks a read start in the same cycle
   assign wr_start = (w_state == W_IDLE) && i_axil.awvalid && i_axil.wvalid;
   assign rd_start = (r_state == R_IDLE) && i_axil.arvalid && !wr_start;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         w_state <= W_IDLE;
         run     <= 1'b0;
      end else begin
         case (w_state)
            W_IDLE: if (wr_start) w_state <= W_ACC;
            W_ACC: begin                              // Both readies high here
               w_state <= W_RESP;
               if (wr_ctrl && i_axil.wstrb[0]) run <= i_axil.wdata[0];
            end
            W_RESP: if (i_axil.bready) w_state <= W_IDLE;
            default: w_state <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (w_state == W_ACC) begin
         bresp <= (wr_mem || wr_ctrl) ? fetch_pkg::RESP_OKAY : fetch_pkg::RESP_SLVERR;
      end
   end

   // Accept, wait on memory, then hold the response
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         r_state <= R_IDLE;
      end else begin
         case (r_state)
            R_IDLE:  if (rd_start) r_state <= R_ACC;
            R_ACC:   r_state <= R_WAIT;                 // Memory read issued
            R_WAIT:  r_state <= R_RESP;                 // Data captured
            R_RESP:  if (i_axil.rready) r_state <= R_IDLE;
            default: r_state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (r_state == R_ACC) begin
         rd_mem  <= ar_mem;
         rd_ctrl <= ar_ctrl;
      end
      if (r_state == R_WAIT) begin
         if (rd_mem) begin
            rdata <= i_ram_rdata;
            rresp <= fetch_pkg::RESP_OKAY;
         end else if (rd_ctrl) begin
            rdata <= {{(fetch_pkg::DATA_W-1){1'b0}}, run};
            rresp <= fetch_pkg::RESP_OKAY;
         end else begin
            rdata <= '0;                                // Unmapped
            rresp <= fetch_pkg::RESP_SLVERR;
         end
      end
   end

   // Memory access, write and read never share a cycle
   always_comb begin
      o_ram = '0;
      if (w_state == W_ACC && wr_mem) begin
         o_ram.en    = 1'b1;
         o_ram.we    = 1'b1;
         o_ram.addr  = word_addr(i_axil.awaddr);
         o_ram.wdata = i_axil.wdata;
         o_ram.strb  = i_axil.wstrb;
      end else if (r_state == R_ACC && ar_mem) begin
         o_ram.en   = 1'b1;
         o_ram.addr = word_addr(i_axil.araddr);
      end
   end

   assign o_axil.awready = (w_state == W_ACC);
   assign o_axil.wready  = (w_state == W_ACC);
   assign o_axil.bvalid  = (w_state == W_RESP);
   assign o_axil.bresp   = bresp;
   assign o_axil.arready = (r_state == R_ACC);
   assign o_axil.rvalid  = (r_state == R_RESP);
   assign o_axil.rdata   = rdata;
   assign o_axil.rresp   = rresp;

   assign o_run = run;

endmodule

`default_nettype wire

//--- src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   // Datapath sizes
   localparam int DATA_W = 32;                  // Word and byte address width
   localparam int JMP_W  = 28;                  // Jump index already shifted by two
   localparam int RAM_AW = 8;                   // Word address bits
   localparam int STRB_W = DATA_W / 8;          // One strobe per byte
   localparam int RAM_DEPTH = 1 << RAM_AW;      // 256 words

   localparam logic [DATA_W-1:0] NOP_INSTR = '0;   // sll $0,$0,0

   // Loader address map, byte addresses
   localparam logic [DATA_W-1:0] RAM_BASE  = 32'h0000_0000;
   localparam logic [DATA_W-1:0] RAM_BYTES = 32'(RAM_DEPTH * 4);   // Ends at 0x400
   localparam logic [DATA_W-1:0] CTRL_ADDR = 32'h0000_0800;         // Bit 0 is run

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Master side of the AXI4-Lite port
   typedef struct packed {
      logic              awvalid;
      logic [DATA_W-1:0] awaddr;
      logic              wvalid;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      logic              bready;
      logic              arvalid;
      logic [DATA_W-1:0] araddr;
      logic              rready;
   } axil_req_t;

   // Slave side
   typedef struct packed {
      logic              awready;
      logic              wready;
      logic              bvalid;
      logic [1:0]        bresp;
      logic              arready;
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
      logic [1:0]        rresp;
   } axil_rsp_t;

   // One loader access on memory port B
   typedef struct packed {
      logic              en;
      logic              we;
      logic [RAM_AW-1:0] addr;    // Word address
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] strb;
   } ram_port_t;

   typedef struct packed {
      logic pc_we;      // Counter enable
      logic if_id_we;   // IF/ID register enable
      logic beq;        // Take branch
      logic jmp;        // Take jump, wins over beq
      logic flush;      // Squash next instruction
   } fetch_ctrl_t;

   typedef struct packed {
      logic [DATA_W-1:0] brq_addr;
      logic [JMP_W-1:0]  jmp_addr;
   } redirect_t;

   typedef struct packed {
      logic [DATA_W-1:0] pc;      // Already pc+4
      logic [DATA_W-1:0] instr;
   } if_id_t;

endpackage

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none

module fetch_stage (
   input  wire logic                            i_clk,
   input  wire logic                            i_rst,
   input  wire logic                            i_run,        // Level from loader
   input  wire fetch_pkg::fetch_ctrl_t          i_ctrl,
   input  wire fetch_pkg::redirect_t            i_redirect,
   output logic                                 o_a_en,       // Memory fetch enable
   output logic      [fetch_pkg::RAM_AW-1:0]    o_a_addr,     // Word address of pc
   input  wire logic [fetch_pkg::DATA_W-1:0]    i_a_data,
   output fetch_pkg::if_id_t                    o_if_id
);

   logic [fetch_pkg::DATA_W-1:0] pc;
   logic [fetch_pkg::DATA_W-1:0] pc_plus4;
   logic [fetch_pkg::DATA_W-1:0] pc_next;
   logic [fetch_pkg::DATA_W-1:0] jmp_target;
   logic [fetch_pkg::DATA_W-1:0] if_id_pc;
   logic                         flushed;     // Instruction slot holds a bubble
   logic                         pc_we;
   logic                         if_id_we;

   // Run low stalls everything
   assign pc_we    = i_run & i_ctrl.pc_we;
   assign if_id_we = i_run & i_ctrl.if_id_we;

   assign pc_plus4 = pc + 32'd4;

   // Region bits from the instruction in decode
   assign jmp_target = {if_id_pc[fetch_pkg::DATA_W-1:fetch_pkg::JMP_W],
                        i_redirect.jmp_addr};

   // Jump beats branch beats sequential
   always_comb begin
      if (i_ctrl.jmp) begin
         pc_next = jmp_target;
      end else if (i_ctrl.beq) begin
         pc_next = i_redirect.brq_addr;
      end else begin
         pc_next = pc_plus4;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else if (pc_we) begin
         pc <= pc_next;
      end
   end

   // IF/ID pc and bubble flag move with the memory read
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         if_id_pc <= '0;
         flushed  <= 1'b1;   // NOP until the first real fetch
      end else if (if_id_we) begin
         if_id_pc <= pc_plus4;
         flushed  <= i_ctrl.flush;
      end
   end

   // Memory register is the IF/ID instruction field
   assign o_a_en   = if_id_we;
   assign o_a_addr = pc[fetch_pkg::RAM_AW+1:2];   // Byte to word

   assign o_if_id.pc    = if_id_pc;
   assign o_if_id.instr = flushed ? fetch_pkg::NOP_INSTR : i_a_data;

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`default_nettype none

module fetch_top (
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire fetch_pkg::axil_req_t    i_axil,       // Program loader bus
   output fetch_pkg::axil_rsp_t         o_axil,
   input  wire fetch_pkg::fetch_ctrl_t  i_ctrl,       // From hazard and control logic
   input  wire fetch_pkg::redirect_t    i_redirect,   // Branch and jump targets
   output fetch_pkg::if_id_t            o_if_id
);

   fetch_pkg::ram_port_t         ram_b;
   logic [fetch_pkg::DATA_W-1:0] ram_b_data;
   logic                         ram_a_en;
   logic [fetch_pkg::RAM_AW-1:0] ram_a_addr;
   logic [fetch_pkg::DATA_W-1:0] ram_a_data;
   logic                         run;          // Fetch allowed

   axil_prog_loader u_loader (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_axil      (i_axil),
      .o_axil      (o_axil),
      .o_ram       (ram_b),
      .i_ram_rdata (ram_b_data),
      .o_run       (run)
   );

   // Port A feeds fetch, port B belongs to the loader
   instr_ram u_ram (
      .i_clk    (i_clk),
      .i_a_en   (ram_a_en),
      .i_a_addr (ram_a_addr),
      .o_a_data (ram_a_data),
      .i_b      (ram_b),
      .o_b_data (ram_b_data)
   );

   fetch_stage u_fetch (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_run      (run),
      .i_ctrl     (i_ctrl),
      .i_redirect (i_redirect),
      .o_a_en     (ram_a_en),
      .o_a_addr   (ram_a_addr),
      .i_a_data   (ram_a_data),
      .o_if_id    (o_if_id)
   );

endmodule

`default_nettype wire

//--- src/instr_ram.sv
`default_nettype none

module instr_ram (
   input  wire logic                            i_clk,
   input  wire logic                            i_a_en,      // Fetch read enable
   input  wire logic [fetch_pkg::RAM_AW-1:0]    i_a_addr,
   output logic      [fetch_pkg::DATA_W-1:0]    o_a_data,
   input  wire fetch_pkg::ram_port_t            i_b,         // Loader access
   output logic      [fetch_pkg::DATA_W-1:0]    o_b_data
);

   logic [fetch_pkg::DATA_W-1:0] mem [fetch_pkg::RAM_DEPTH];

   // Program space comes up cleared
   initial begin
      for (int i = 0; i < fetch_pkg::RAM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   // Port A, read only
   always_ff @(posedge i_clk) begin
      if (i_a_en) begin
         o_a_data <= mem[i_a_addr];   // Old word on a same-cycle write
      end
   end

   // Port B, read with byte-strobed write
   always @(posedge i_clk) begin
      if (i_b.en) begin
         if (i_b.we) begin
            for (int k = 0; k < fetch_pkg::STRB_W; k++) begin
               if (i_b.strb[k]) mem[i_b.addr][8*k +: 8] <= i_b.wdata[8*k +: 8];
            end
         end
         o_b_data <= mem[i_b.addr];   // Read before write
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
src/fetch_pkg.sv
src/instr_ram.sv
src/fetch_stage.sv
src/axil_prog_loader.sv
src/fetch_top.sv
bench/fetch_tb_assertions.sv
bench/fetch_tb.sv
